/* Bender.yml */
package:
  name: xaui_phy

sources:
  - hdl/xaui_pkg.sv
  - hdl/xaui_tx_encode.sv
  - hdl/xaui_rx_decode.sv
  - hdl/xaui_lane_sync.sv
  - hdl/xaui_link_monitor.sv
  - hdl/xaui_phy.sv
  - target: test
    files:
      - dv/xaui_phy_tb.sv

/* dv/xaui_phy_stim.txt */
// test_mode_count_ctrl_byte_expbyte_valid_comma_buferr_lock_syncok_xreset_status_ea_cs_rst
// modes: 00 hold then check, 01 tx check, 02 rx check, 03 reset pulse, 04 drive only
01_01_03_FF_07_BC_FF_00_0_F_F_0_02_F_0_FF
01_01_03_F0_FD_FD_FF_00_0_F_F_0_02_F_0_FF
01_01_08_00_00_00_FF_00_0_F_F_0_02_F_0_FF
02_03_C8_00_00_00_FF_00_0_F_F_0_02_F_0_0F
02_03_C8_00_00_00_FF_00_0_F_F_0_02_F_0_0F
02_02_08_00_00_00_FF_00_0_F_F_0_02_F_0_FF
02_00_02_00_00_00_FF_00_0_F_F_0_02_F_0_FF
03_04_08_FF_BC_07_FF_FF_0_F_F_0_7C_0_1_FF
03_00_04_00_00_00_FF_00_0_F_F_0_7C_0_1_FF
03_00_50_00_00_00_FF_00_0_F_F_0_7C_0_1_00
04_02_08_00_00_00_FF_00_0_F_F_0_7C_0_1_FF
04_02_02_FF_BC_07_FF_FF_0_F_F_0_7C_0_1_FF
04_02_02_0F_FB_FB_FF_00_0_F_F_0_7C_0_1_FF
04_02_01_00_00_00_FE_00_0_F_F_0_7C_0_1_FF
04_02_01_00_00_00_7F_00_0_F_F_0_7C_0_1_FF
04_00_04_00_00_00_FF_00_0_F_F_0_7C_0_1_00
05_04_03_00_00_00_CF_00_0_F_F_0_7C_0_1_FF
05_00_05_00_00_00_FF_00_0_F_F_0_2E_4_0_FF
05_02_06_00_00_00_FF_00_0_F_F_0_2E_4_0_FF
05_03_C8_00_00_00_FF_00_0_F_F_0_2E_4_0_0F
06_04_08_FF_BC_07_FF_FF_0_F_F_0_7C_0_1_FF
06_00_50_00_00_00_FF_00_0_F_F_0_7C_0_1_00
06_03_06_00_00_00_FF_00_1_F_F_0_7C_0_1_0F
06_03_0A_00_00_00_FF_00_0_F_0_0_3E_0_1_0F
06_00_14_00_00_00_FF_00_0_F_0_0_3E_0_1_00
06_03_06_00_00_00_FF_00_0_F_0_1_3E_0_1_0F

/* dv/xaui_phy_tb.sv */
`timescale 1ns/10ps

module xaui_phy_tb;

  localparam int MAX_REC = 64;

  logic        mgt_clk;
  logic        mgt_rx_reset_stretch;
  logic [63:0] xgmii_txd;
  logic [7:0]  xgmii_txc;
  logic [63:0] xgmii_rxd;
  logic [7:0]  xgmii_rxc;
  logic        xaui_reset;
  logic [7:0]  xaui_status;
  logic [63:0] mgt_txdata;
  logic [7:0]  mgt_txcharisk;
  logic [63:0] mgt_rxdata;
  logic [7:0]  mgt_rxcharisk;
  logic [7:0]  mgt_code_valid;
  logic [7:0]  mgt_code_comma;
  logic [3:0]  mgt_rxbufferr;
  logic [3:0]  mgt_rxlock;
  logic [3:0]  mgt_syncok;
  logic [3:0]  mgt_enable_align;
  logic        mgt_en_chan_sync;
  logic [3:0]  mgt_rx_reset;

  logic [103:0] stim_mem [0:MAX_REC-1];
  int           num_rec;
  int           watchdog_cycles = 0;
  int           errors = 0;
  int           test_errors = 0;
  int           checks = 0;
  logic [31:0]  rng_state = 32'hf45a17ee;

  // Next cycle's inputs and expected outputs
  logic [63:0] d_txd, d_rxd;
  logic [7:0]  d_txc, d_rxk, d_valid, d_comma;
  logic [3:0]  d_buferr, d_lock, d_sok;
  logic        d_xrst, d_tx_chk, d_rx_chk;
  logic [71:0] d_tx_exp, d_rx_exp;

  logic [71:0] tx_exp [0:1];                      // Index 0 is newest
  logic [1:0]  tx_chk = '0;
  logic [71:0] rx_exp [0:2];
  logic [2:0]  rx_chk = '0;

  xaui_phy #(
    .COMMA_COUNT  (4),
    .HOLDOFF_BITS (6)
  ) u_xaui_phy (.*);

  initial begin
    mgt_clk = 1'b0;
    forever #2 mgt_clk = ~mgt_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [71:0] got,
                             input logic [71:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  // One cycle of inputs from a record, payload bytes random
  task automatic build_cycle(input logic [103:0] r);
    logic [7:0]  ctrl;
    logic [63:0] rnd;
    logic [71:0] rx_e;
    ctrl = r[79:72];
    rng_state = xorshift(rng_state);
    rnd[31:0] = rng_state;
    rng_state = xorshift(rng_state);
    rnd[63:32] = rng_state;
    d_txd = rnd;
    d_rxd = rnd;
    d_tx_exp = {rnd, 8'h00};
    rx_e = {rnd, 8'h00};
    for (int i = 0; i < 8; i++) begin
      if (ctrl[i]) begin
        d_txd[8*i +: 8] = r[71:64];
        d_rxd[8*i +: 8] = r[71:64];
        d_tx_exp[8+8*i +: 8] = r[63:56];          // Mapped control character
        d_tx_exp[i] = 1'b1;
        rx_e[8+8*i +: 8] = r[63:56];
        rx_e[i] = 1'b1;
      end
      if (!r[48+i]) begin
        rx_e[8+8*i +: 8] = 8'hFE;                 // Invalid code
        rx_e[i] = 1'b1;
      end
    end
    if (!r[22]) begin
      rx_e = {{8{8'h07}}, 8'hFF};                 // Unaligned gives idle
    end
    d_txc = ctrl;
    d_rxk = ctrl;
    d_rx_exp = rx_e;
    d_tx_chk = (r[95:88] == 8'h01);
    d_rx_chk = (r[95:88] == 8'h02);
    d_valid = r[55:48];
    d_comma = r[47:40];
    d_buferr = r[39:36];
    d_lock = r[35:32];
    d_sok = r[31:28];
    d_xrst = r[24];
  endtask

  // Check the pipelines on the edge, then drive the next inputs
  task automatic step();
    @(posedge mgt_clk);
    if (tx_chk[1]) check_value("mgt_tx", {mgt_txdata, mgt_txcharisk}, tx_exp[1]);
    if (rx_chk[2]) check_value("xgmii_rx", {xgmii_rxd, xgmii_rxc}, rx_exp[2]);
    tx_exp[1] = tx_exp[0];
    tx_exp[0] = d_tx_exp;
    tx_chk = {tx_chk[0], d_tx_chk};
    rx_exp[2] = rx_exp[1];
    rx_exp[1] = rx_exp[0];
    rx_exp[0] = d_rx_exp;
    rx_chk = {rx_chk[1:0], d_rx_chk};
    xgmii_txd      <= d_txd;
    xgmii_txc      <= d_txc;
    mgt_rxdata     <= d_rxd;
    mgt_rxcharisk  <= d_rxk;
    mgt_code_valid <= d_valid;
    mgt_code_comma <= d_comma;
    mgt_rxbufferr  <= d_buferr;
    mgt_rxlock     <= d_lock;
    mgt_syncok     <= d_sok;
    xaui_reset     <= d_xrst;
  endtask

  task automatic measure_pulse(input logic [103:0] r);
    int   waited;
    int   width;
    logic prev;
    logic rise;
    prev = mgt_rx_reset[0];
    rise = 1'b0;
    waited = 0;
    width = 0;
    build_cycle(r);
    while (!rise && waited < int'(r[87:80])) begin
      step();
      d_buferr = '0;                              // Single-cycle events
      d_xrst = 1'b0;
      waited++;
      rise = mgt_rx_reset[0] && !prev;
      prev = mgt_rx_reset[0];
    end
    if (!rise) begin
      $display("no receive reset pulse started within %0d cycles", r[87:80]);
      errors++;
      test_errors++;
      return;
    end
    while (mgt_rx_reset[0] && width < 40) begin
      width++;
      step();
    end
    check_value("mgt_rx_reset width", 72'(width), 72'(r[7:0]));
  endtask

  task automatic end_check(input logic [103:0] r);
    check_value("xaui_status", 72'(xaui_status), 72'(r[23:16]));
    check_value("mgt_enable_align", 72'(mgt_enable_align), 72'(r[15:12]));
    check_value("mgt_en_chan_sync", 72'(mgt_en_chan_sync), 72'(r[8]));
    if (r[7:0] != 8'hFF) begin
      check_value("mgt_rx_reset", 72'(mgt_rx_reset), 72'({4{r[0]}}));
    end
  endtask

  task automatic report_test(input logic [7:0] num);
    $display("test %0d finished with %0d errors", num, test_errors);
    test_errors = 0;
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    logic [103:0] r;
    logic [7:0]   cur_test;
    logic         rst_prev;
    mgt_rx_reset_stretch = 1'b1;
    xgmii_txd = '0;
    xgmii_txc = '1;
    mgt_rxdata = '0;
    mgt_rxcharisk = '0;
    mgt_code_valid = '1;
    mgt_code_comma = '0;
    mgt_rxbufferr = '0;
    mgt_rxlock = '1;
    mgt_syncok = '1;
    xaui_reset = 1'b0;
    for (int i = 0; i < MAX_REC; i++) stim_mem[i] = '0;
    $readmemh("dv/xaui_phy_stim.txt", stim_mem);
    num_rec = 0;
    watchdog_cycles = 400;
    while (num_rec < MAX_REC && stim_mem[num_rec][103:96] != 8'h00) begin
      watchdog_cycles += int'(stim_mem[num_rec][87:80]) + 8;
      num_rec++;
    end
    repeat (10) @(posedge mgt_clk);
    mgt_rx_reset_stretch <= 1'b0;
    cur_test = stim_mem[0][103:96];
    for (int i = 0; i < num_rec; i++) begin
      r = stim_mem[i];
      if (r[103:96] != cur_test) begin
        report_test(cur_test);
        cur_test = r[103:96];
      end
      if (r[95:88] == 8'h03) begin
        measure_pulse(r);
      end else begin
        rst_prev = mgt_rx_reset[0];
        for (int c = 0; c < int'(r[87:80]); c++) begin
          build_cycle(r);
          step();
          if (r[95:88] == 8'h00 && r[7:0] == 8'h00) begin
            if (mgt_rx_reset[0] && !rst_prev) begin // No new pulse in a quiet hold
              $display("receive reset pulse started at t=%0t during a quiet hold", $time);
              errors++;
              test_errors++;
            end
          end
          rst_prev = mgt_rx_reset[0];
        end
        if (r[95:88] == 8'h00) end_check(r);
      end
    end
    d_tx_chk = 1'b0;
    d_rx_chk = 1'b0;
    repeat (3) step();                            // Drain pipelines
    report_test(cur_test);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge mgt_clk);
    $display("watchdog expired before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* hdl/xaui_lane_sync.sv */
`timescale 1ns/10ps

module xaui_lane_sync #(
  parameter int COMMA_COUNT = xaui_pkg::COMMA_COUNT_DEFAULT
) (
  input  logic                             mgt_clk,
  input  logic                             mgt_rx_reset_stretch,
  input  xaui_pkg::mgt_rx_flags_t          mgt_rx_flags,
  output logic [xaui_pkg::NUM_LANES-1:0]   lane_synced,
  output logic [xaui_pkg::NUM_LANES-1:0]   enable_align
);
  import xaui_pkg::*;

  localparam int CNT_W = $clog2(COMMA_COUNT + 1);

  // ======================================================================
  // One code-group sync machine per lane
  // ======================================================================
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
    sync_state_e      state;
    logic [CNT_W-1:0] comma_cnt;
    logic [1:0]       bad_cnt;                       // Consecutive invalid cycles
    logic             comma_seen;
    logic             code_bad;

    assign comma_seen = |mgt_rx_flags.code_comma[2*lane +: 2];
    assign code_bad   = ~&mgt_rx_flags.code_valid[2*lane +: 2];

    always_ff @(posedge mgt_clk) begin
      if (mgt_rx_reset_stretch) begin
        state     <= SYNC_LOSS;
        comma_cnt <= '0;
        bad_cnt   <= '0;
      end else begin
        case (state)
          SYNC_LOSS: begin
            bad_cnt <= '0;
            if (comma_seen) begin
              comma_cnt <= CNT_W'(1);
              state     <= (COMMA_COUNT <= 1) ? SYNC_OK : SYNC_ACQ;
            end
          end
          SYNC_ACQ: begin
            if (!comma_seen) begin
              state <= SYNC_LOSS;                    // Run broken
            end else if (comma_cnt == CNT_W'(COMMA_COUNT - 1)) begin
              state <= SYNC_OK;
            end else begin
              comma_cnt <= comma_cnt + 1'b1;
            end
          end
          SYNC_OK: begin
            if (!mgt_rx_flags.rxlock[lane]) begin
              state <= SYNC_LOSS;                    // CDR lost lock
            end else if (code_bad) begin
              bad_cnt <= bad_cnt + 1'b1;
              if (bad_cnt == 2'd2) begin
                state <= SYNC_LOSS;
              end
            end else begin
              bad_cnt <= '0;
            end
          end
          default: state <= SYNC_LOSS;
        endcase
      end
    end

    assign lane_synced[lane]  = (state == SYNC_OK);
    assign enable_align[lane] = (state != SYNC_OK); // Comma align while hunting
  end

  a_align_vs_sync: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
      (enable_align & lane_synced) == '0
  ) else $error("lane aligning while synced");

endmodule

/* hdl/xaui_link_monitor.sv */
`timescale 1ns/10ps

module xaui_link_monitor #(
  parameter int HOLDOFF_BITS = xaui_pkg::HOLDOFF_BITS_DEFAULT
) (
  input  logic                             mgt_clk,
  input  logic                             mgt_rx_reset_stretch,
  input  xaui_pkg::xgmii_word_t            rx_decoded,
  input  logic [xaui_pkg::NUM_LANES-1:0]   lane_synced,
  input  logic [xaui_pkg::NUM_LANES-1:0]   syncok,
  input  logic [xaui_pkg::NUM_LANES-1:0]   rxbufferr,
  input  logic                             xaui_reset,
  output xaui_pkg::xgmii_word_t            xgmii_rx,
  output xaui_pkg::link_status_t           status,
  output logic                             en_chan_sync,
  output logic [xaui_pkg::NUM_LANES-1:0]   rx_reset
);
  import xaui_pkg::*;

  localparam logic [3:0] STRETCH_LOAD = 4'hf;     // 15-cycle reset pulse

  logic                    align;
  logic [NUM_LANES-1:0]    lane_sync_q;
  sup_state_e              sup_state;
  logic [HOLDOFF_BITS-1:0] holdoff_cnt;
  logic [3:0]              stretch_cnt;
  logic                    stretch_load;

  // ======================================================================
  // Alignment and status
  // ======================================================================
  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      align       <= 1'b0;
      lane_sync_q <= '0;
    end else begin
      align       <= (&lane_synced) & (&syncok);  // Bonding done too
      lane_sync_q <= lane_synced;
    end
  end

  assign en_chan_sync = &lane_synced;

  always_comb begin
    status.reserved  = 1'b0;
    status.align     = align;
    status.lane_sync = lane_sync_q;
    status.rx_fault  = ~align;
    status.tx_fault  = 1'b0;
  end

  // Idle to the client until the link is aligned
  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch || !align) begin
      xgmii_rx.data <= {(2 * NUM_LANES){XGMII_IDLE}};
      xgmii_rx.ctrl <= '1;
    end else begin
      xgmii_rx <= rx_decoded;
    end
  end

  // ======================================================================
  // Receive reset supervisor
  // ======================================================================
  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch || xaui_reset) begin
      sup_state   <= SUP_LOOK;
      holdoff_cnt <= '0;
    end else begin
      case (sup_state)
        SUP_LOOK: begin
          if (!align) begin
            holdoff_cnt <= '1;
            sup_state   <= SUP_WAIT;
          end
        end
        SUP_WAIT: begin
          holdoff_cnt <= holdoff_cnt - 1'b1;
          if (holdoff_cnt == HOLDOFF_BITS'(1)) begin
            sup_state <= SUP_LOOK;                // Look at align again
          end
        end
        default: sup_state <= SUP_LOOK;
      endcase
    end
  end

  assign stretch_load = ((sup_state == SUP_LOOK) && !align) || (|rxbufferr);

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch || xaui_reset) begin
      stretch_cnt <= '0;
    end else if (stretch_load) begin
      stretch_cnt <= STRETCH_LOAD;
    end else if (|stretch_cnt) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  assign rx_reset = {NUM_LANES{|stretch_cnt}};

  a_stretch_source: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch || xaui_reset)
      (stretch_cnt == STRETCH_LOAD) |-> $past((sup_state == SUP_LOOK) || (|rxbufferr))
  ) else $error("rx reset stretch loaded outside LOOK");

endmodule

/* hdl/xaui_phy.sv */
`timescale 1ns/10ps

module xaui_phy #(
  parameter int COMMA_COUNT  = xaui_pkg::COMMA_COUNT_DEFAULT,
  parameter int HOLDOFF_BITS = xaui_pkg::HOLDOFF_BITS_DEFAULT
) (
  input  logic        mgt_clk,
  input  logic        mgt_rx_reset_stretch,
  // XGMII client side
  input  logic [63:0] xgmii_txd,
  input  logic [7:0]  xgmii_txc,
  output logic [63:0] xgmii_rxd,
  output logic [7:0]  xgmii_rxc,
  input  logic        xaui_reset,
  output logic [7:0]  xaui_status,
  // MGT side
  output logic [63:0] mgt_txdata,
  output logic [7:0]  mgt_txcharisk,
  input  logic [63:0] mgt_rxdata,
  input  logic [7:0]  mgt_rxcharisk,
  input  logic [7:0]  mgt_code_valid,
  input  logic [7:0]  mgt_code_comma,
  input  logic [3:0]  mgt_rxbufferr,
  input  logic [3:0]  mgt_rxlock,
  input  logic [3:0]  mgt_syncok,
  output logic [3:0]  mgt_enable_align,
  output logic        mgt_en_chan_sync,
  output logic [3:0]  mgt_rx_reset
);
  import xaui_pkg::*;

  xgmii_word_t          xgmii_tx;
  xgmii_word_t          rx_decoded;
  xgmii_word_t          xgmii_rx;
  mgt_word_t            mgt_tx;
  mgt_word_t            mgt_rx;
  mgt_rx_flags_t        mgt_rx_flags;
  logic [NUM_LANES-1:0] lane_synced;
  link_status_t         status;

  // ======================================================================
  // Port packing
  // ======================================================================
  assign xgmii_tx.data           = xgmii_txd;
  assign xgmii_tx.ctrl           = xgmii_txc;
  assign mgt_rx.data             = mgt_rxdata;
  assign mgt_rx.charisk          = mgt_rxcharisk;
  assign mgt_rx_flags.code_valid = mgt_code_valid;
  assign mgt_rx_flags.code_comma = mgt_code_comma;
  assign mgt_rx_flags.rxbufferr  = mgt_rxbufferr;
  assign mgt_rx_flags.rxlock     = mgt_rxlock;
  assign mgt_rx_flags.syncok     = mgt_syncok;

  assign mgt_txdata    = mgt_tx.data;
  assign mgt_txcharisk = mgt_tx.charisk;
  assign xgmii_rxd     = xgmii_rx.data;
  assign xgmii_rxc     = xgmii_rx.ctrl;
  assign xaui_status   = status;

  // ======================================================================
  // Blocks
  // ======================================================================
  xaui_tx_encode u_tx_encode (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xgmii_tx             (xgmii_tx),
    .mgt_tx               (mgt_tx)
  );

  xaui_rx_decode u_rx_decode (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .mgt_rx               (mgt_rx),
    .code_valid           (mgt_rx_flags.code_valid),
    .rx_decoded           (rx_decoded)
  );

  xaui_lane_sync #(
    .COMMA_COUNT (COMMA_COUNT)
  ) u_lane_sync (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .mgt_rx_flags         (mgt_rx_flags),
    .lane_synced          (lane_synced),
    .enable_align         (mgt_enable_align)
  );

  xaui_link_monitor #(
    .HOLDOFF_BITS (HOLDOFF_BITS)
  ) u_link_monitor (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .rx_decoded           (rx_decoded),
    .lane_synced          (lane_synced),
    .syncok               (mgt_rx_flags.syncok),
    .rxbufferr            (mgt_rx_flags.rxbufferr),
    .xaui_reset           (xaui_reset),
    .xgmii_rx             (xgmii_rx),
    .status               (status),
    .en_chan_sync         (mgt_en_chan_sync),
    .rx_reset             (mgt_rx_reset)
  );

endmodule

/* hdl/xaui_pkg.sv */
package xaui_pkg;

  // ======================================================================
  // Lane and character constants
  // ======================================================================
  localparam int NUM_LANES = 4;                   // 16 bits per lane
  localparam logic [7:0] XGMII_IDLE  = 8'h07;
  localparam logic [7:0] XGMII_ERROR = 8'hFE;
  localparam logic [7:0] K28_5       = 8'hBC;     // Comma

  localparam int COMMA_COUNT_DEFAULT  = 4;
  localparam int HOLDOFF_BITS_DEFAULT = 24;

  // ======================================================================
  // Word and status types
  // ======================================================================
  typedef struct packed {
    logic [7:0][7:0] data;
    logic [7:0]      ctrl;
  } xgmii_word_t;

  typedef struct packed {
    logic [7:0][7:0] data;
    logic [7:0]      charisk;
  } mgt_word_t;

  typedef struct packed {
    logic [7:0] code_valid;
    logic [7:0] code_comma;
    logic [3:0] rxbufferr;
    logic [3:0] rxlock;
    logic [3:0] syncok;
  } mgt_rx_flags_t;

  typedef struct packed {
    logic       reserved;                         // Bit 7
    logic       align;                            // Bit 6
    logic [3:0] lane_sync;                        // Bits 5..2
    logic       rx_fault;
    logic       tx_fault;                         // Bit 0
  } link_status_t;

  typedef enum logic [1:0] {SYNC_LOSS, SYNC_ACQ, SYNC_OK} sync_state_e;
  typedef enum logic {SUP_LOOK, SUP_WAIT} sup_state_e;

endpackage

/* hdl/xaui_rx_decode.sv */
`timescale 1ns/10ps

module xaui_rx_decode (
  input  logic                                 mgt_clk,
  input  logic                                 mgt_rx_reset_stretch,
  input  xaui_pkg::mgt_word_t                  mgt_rx,
  input  logic [2*xaui_pkg::NUM_LANES-1:0]     code_valid,
  output xaui_pkg::xgmii_word_t                rx_decoded
);
  import xaui_pkg::*;

  xgmii_word_t rx_next;

  // ======================================================================
  // Per-byte character mapping
  // ======================================================================
  always_comb begin
    for (int i = 0; i < 2 * NUM_LANES; i++) begin
      if (!code_valid[i]) begin
        rx_next.data[i] = XGMII_ERROR;              // Bad 8b/10b code
        rx_next.ctrl[i] = 1'b1;
      end else if (mgt_rx.charisk[i]) begin
        if (mgt_rx.data[i] == K28_5) begin
          rx_next.data[i] = XGMII_IDLE;
        end else begin
          rx_next.data[i] = mgt_rx.data[i];         // /S/, /T/ and friends
        end
        rx_next.ctrl[i] = 1'b1;
      end else begin
        rx_next.data[i] = mgt_rx.data[i];
        rx_next.ctrl[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      rx_decoded.data <= {(2 * NUM_LANES){XGMII_IDLE}};
      rx_decoded.ctrl <= '1;
    end else begin
      rx_decoded <= rx_next;
    end
  end

endmodule

/* hdl/xaui_tx_encode.sv */
`timescale 1ns/10ps

module xaui_tx_encode (
  input  logic                  mgt_clk,
  input  logic                  mgt_rx_reset_stretch,
  input  xaui_pkg::xgmii_word_t xgmii_tx,
  output xaui_pkg::mgt_word_t   mgt_tx
);
  import xaui_pkg::*;

  mgt_word_t mgt_tx_next;

  // Idle becomes comma, other control characters go out as K codes
  always_comb begin
    for (int i = 0; i < 2 * NUM_LANES; i++) begin
      if (xgmii_tx.ctrl[i] && (xgmii_tx.data[i] == XGMII_IDLE)) begin
        mgt_tx_next.data[i] = K28_5;
      end else begin
        mgt_tx_next.data[i] = xgmii_tx.data[i];
      end
      mgt_tx_next.charisk[i] = xgmii_tx.ctrl[i];
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      mgt_tx.data    <= {(2 * NUM_LANES){K28_5}};  // Commas on every lane
      mgt_tx.charisk <= '1;
    end else begin
      mgt_tx <= mgt_tx_next;
    end
  end

  // ======================================================================
  // Checks
  // ======================================================================
  property p_charisk_needs_ctrl;
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
      !$past(mgt_rx_reset_stretch) |->
        ((mgt_tx.charisk & ~$past(xgmii_tx.ctrl)) == '0);
  endproperty

  a_charisk_needs_ctrl: assert property (p_charisk_needs_ctrl)
    else $error("charisk set on a data byte");

endmodule

/* sim.f */
hdl/xaui_pkg.sv
hdl/xaui_tx_encode.sv
hdl/xaui_rx_decode.sv
hdl/xaui_lane_sync.sv
hdl/xaui_link_monitor.sv
hdl/xaui_phy.sv
dv/xaui_phy_tb.sv
